// File: Bender.yml
package:
  name: rv_decode_stage

sources:
  - include_dirs:
      - .
    files:
      - rv_decode_pkg.sv
      - rv_instr_decoder.sv
      - rv_decode_gate.sv
      - rv_pc_ctrl.sv
      - rv_decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - decode_assertions.sv
      - tb_decode_stage.sv

// File: decode_assertions.sv
// --------------------
// decode stage protocol assertions
// handshake, suppression and redirect rules
// --------------------

`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module decode_assertions (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   cir_use_o,
	input logic                   starved_o,
	input logic                   x_stall_i,
	input logic                   jump_now_i,
	input logic [`XLEN-1:0]       jump_target_i,
	input logic [`XLEN-1:0]       pc_o,
	input rv_decode_pkg::mem_op_e memop_o
);
	import rv_decode_pkg::*;

	// read by the testbench at the end of the run
	int fail_count = 0;

	use_needs_word: assert property (@(posedge clk) disable iff (!rst_n)
		!(cir_use_o && starved_o))
	else begin
		fail_count++;
		$error("cir_use_o high while the instruction buffer is empty");
	end

	use_held_by_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!(cir_use_o && x_stall_i))
	else begin
		fail_count++;
		$error("cir_use_o high while execute stalls");
	end

	starved_no_mem: assert property (@(posedge clk) disable iff (!rst_n)
		starved_o |-> memop_o == MEMOP_NONE)
	else begin
		fail_count++;
		$error("memory operation issued for a starved instruction");
	end

	// the redirect lands one clock after the request
	jump_loads_pc: assert property (@(posedge clk) disable iff (!rst_n)
		jump_now_i |=> pc_o == $past(jump_target_i))
	else begin
		fail_count++;
		$error("pc_o did not take the jump target");
	end

endmodule

bind rv_decode_stage decode_assertions decode_asserts0 (
	.clk           (clk),
	.rst_n         (rst_n),
	.cir_use_o     (cir_use_o),
	.starved_o     (starved_o),
	.x_stall_i     (x_stall_i),
	.jump_now_i    (jump_now_i),
	.jump_target_i (jump_target_i),
	.pc_o          (pc_o),
	.memop_o       (memop_o)
);

// File: list.f
+incdir+.
rv_decode_pkg.sv
rv_instr_decoder.sv
rv_decode_gate.sv
rv_pc_ctrl.sv
rv_decode_stage.sv
decode_assertions.sv
tb_decode_stage.sv

// File: rv_decode_defs.svh
// --------------------
// RV32I decode stage shared constants
// widths, reset vector and instruction field positions
// --------------------

`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// data path and address width
`define XLEN 32

// register file address width, 32 integer registers
`define REG_ADDR_W 5

// PC value loaded by reset
`define RESET_VECTOR 32'h0000_0000

// major opcode field inside the instruction word
`define OPC_LSB 0
`define OPC_MSB 6

`endif

// File: rv_decode_gate.sv
// --------------------
// decode output gate
// nulls the raw decode of a starved, faulted or illegal
// instruction and raises the matching exception
// --------------------

`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_decode_gate (
	input  logic [`REG_ADDR_W-1:0]    rs1_i,
	input  logic [`REG_ADDR_W-1:0]    rs2_i,
	input  logic [`REG_ADDR_W-1:0]    rd_i,
	input  logic [`XLEN-1:0]          imm_i,
	input  rv_decode_pkg::alusrc_a_e  alusrc_a_i,
	input  rv_decode_pkg::alusrc_b_e  alusrc_b_i,
	input  rv_decode_pkg::alu_op_e    aluop_i,
	input  rv_decode_pkg::mem_op_e    memop_i,
	input  rv_decode_pkg::bcond_e     branchcond_i,
	input  logic [`XLEN-1:0]          addr_offs_i,
	input  logic                      addr_is_regoffs_i,
	input  rv_decode_pkg::except_e    except_i,
	input  logic                      illegal_i,
	input  logic                      starved_i,
	input  logic                      cir_err_i,
	output logic [`REG_ADDR_W-1:0]    rs1_o,
	output logic [`REG_ADDR_W-1:0]    rs2_o,
	output logic [`REG_ADDR_W-1:0]    rd_o,
	output logic [`XLEN-1:0]          imm_o,
	output rv_decode_pkg::alusrc_a_e  alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e  alusrc_b_o,
	output rv_decode_pkg::alu_op_e    aluop_o,
	output rv_decode_pkg::mem_op_e    memop_o,
	output rv_decode_pkg::bcond_e     branchcond_o,
	output logic [`XLEN-1:0]          addr_offs_o,
	output logic                      addr_is_regoffs_o,
	output rv_decode_pkg::except_e    except_o
);
	import rv_decode_pkg::*;

	logic bus_fault;
	logic suppress;

	// a fetch error only counts when there is a word to blame it on
	assign bus_fault = cir_err_i && !starved_i;
	assign suppress  = bus_fault || starved_i || illegal_i;

	// operand fields are harmless and pass through unchanged
	assign imm_o       = imm_i;
	assign alusrc_a_o  = alusrc_a_i;
	assign alusrc_b_o  = alusrc_b_i;
	assign aluop_o     = aluop_i;
	assign addr_offs_o = addr_offs_i;

	always_comb begin
		rs1_o             = suppress ? '0 : rs1_i;
		rs2_o             = suppress ? '0 : rs2_i;
		rd_o              = suppress ? '0 : rd_i;
		memop_o           = suppress ? MEMOP_NONE : memop_i;
		branchcond_o      = suppress ? BCOND_NEVER : branchcond_i;
		// keeps the address bus quiet with rs1 forced to x0
		addr_is_regoffs_o = suppress ? 1'b1 : addr_is_regoffs_i;
		if (bus_fault)
			except_o = EXCEPT_INSTR_FAULT;
		else if (illegal_i && !starved_i)
			except_o = EXCEPT_INSTR_ILLEGAL;
		else if (suppress)
			except_o = EXCEPT_NONE;
		else
			except_o = except_i;
	end

endmodule

// File: rv_decode_pkg.sv
// --------------------
// RV32I decode stage types
// opcodes and the control field encodings seen by execute
// --------------------

`include "rv_decode_defs.svh"

package rv_decode_pkg;

	// major opcodes of the RV32I base set
	typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_OP_IMM   = 7'b0010011,
		OPC_AUIPC    = 7'b0010111,
		OPC_STORE    = 7'b0100011,
		OPC_OP       = 7'b0110011,
		OPC_LUI      = 7'b0110111,
		OPC_BRANCH   = 7'b1100011,
		OPC_JALR     = 7'b1100111,
		OPC_JAL      = 7'b1101111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	// ALU operations, RS2 passes operand B straight to the result
	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_SLL, ALUOP_LT, ALUOP_LTU, ALUOP_XOR,
		ALUOP_SRL, ALUOP_SRA, ALUOP_OR, ALUOP_AND, ALUOP_RS2
	} alu_op_e;

	typedef enum logic [3:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU, MEMOP_LHU,
		MEMOP_SB, MEMOP_SH, MEMOP_SW
	} mem_op_e;

	// branch taken when the ALU result matches the condition
	typedef enum logic [1:0] {
		BCOND_NEVER, BCOND_ALWAYS, BCOND_ZERO, BCOND_NZERO
	} bcond_e;

	typedef enum logic {
		ALUSRCA_RS1, ALUSRCA_PC
	} alusrc_a_e;

	typedef enum logic {
		ALUSRCB_RS2, ALUSRCB_IMM
	} alusrc_b_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE, EXCEPT_INSTR_FAULT, EXCEPT_INSTR_ILLEGAL, EXCEPT_ECALL, EXCEPT_EBREAK
	} except_e;

endpackage

// File: rv_decode_stage.sv
// --------------------
// RV32I decode stage
// raw decoder, output gate and PC control
// --------------------

`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_decode_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`XLEN-1:0]          cir_i,
	input  logic                      cir_vld_i,
	input  logic                      cir_err_i,
	input  logic                      x_stall_i,
	input  logic                      jump_now_i,
	input  logic [`XLEN-1:0]          jump_target_i,
	output logic                      cir_use_o,
	output logic                      starved_o,
	output logic [`XLEN-1:0]          pc_o,
	output logic [`REG_ADDR_W-1:0]    rs1_o,
	output logic [`REG_ADDR_W-1:0]    rs2_o,
	output logic [`REG_ADDR_W-1:0]    rd_o,
	output logic [`XLEN-1:0]          imm_o,
	output rv_decode_pkg::alusrc_a_e  alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e  alusrc_b_o,
	output rv_decode_pkg::alu_op_e    aluop_o,
	output rv_decode_pkg::mem_op_e    memop_o,
	output rv_decode_pkg::bcond_e     branchcond_o,
	output logic [`XLEN-1:0]          addr_offs_o,
	output logic                      addr_is_regoffs_o,
	output rv_decode_pkg::except_e    except_o
);
	import rv_decode_pkg::*;

	// raw decode before gating
	logic [`REG_ADDR_W-1:0] raw_rs1;
	logic [`REG_ADDR_W-1:0] raw_rs2;
	logic [`REG_ADDR_W-1:0] raw_rd;
	logic [`XLEN-1:0]       raw_imm;
	alusrc_a_e              raw_alusrc_a;
	alusrc_b_e              raw_alusrc_b;
	alu_op_e                raw_aluop;
	mem_op_e                raw_memop;
	bcond_e                 raw_branchcond;
	logic [`XLEN-1:0]       raw_addr_offs;
	logic                   raw_addr_is_regoffs;
	except_e                raw_except;
	logic                   raw_illegal;

	rv_pc_ctrl pc_ctrl0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.cir_vld_i     (cir_vld_i),
		.x_stall_i     (x_stall_i),
		.jump_now_i    (jump_now_i),
		.jump_target_i (jump_target_i),
		.starved_o     (starved_o),
		.cir_use_o     (cir_use_o),
		.pc_o          (pc_o)
	);

	rv_instr_decoder decoder0 (
		.instr_i           (cir_i),
		.rs1_o             (raw_rs1),
		.rs2_o             (raw_rs2),
		.rd_o              (raw_rd),
		.imm_o             (raw_imm),
		.alusrc_a_o        (raw_alusrc_a),
		.alusrc_b_o        (raw_alusrc_b),
		.aluop_o           (raw_aluop),
		.memop_o           (raw_memop),
		.branchcond_o      (raw_branchcond),
		.addr_offs_o       (raw_addr_offs),
		.addr_is_regoffs_o (raw_addr_is_regoffs),
		.except_o          (raw_except),
		.illegal_o         (raw_illegal)
	);

	rv_decode_gate gate0 (
		.rs1_i             (raw_rs1),
		.rs2_i             (raw_rs2),
		.rd_i              (raw_rd),
		.imm_i             (raw_imm),
		.alusrc_a_i        (raw_alusrc_a),
		.alusrc_b_i        (raw_alusrc_b),
		.aluop_i           (raw_aluop),
		.memop_i           (raw_memop),
		.branchcond_i      (raw_branchcond),
		.addr_offs_i       (raw_addr_offs),
		.addr_is_regoffs_i (raw_addr_is_regoffs),
		.except_i          (raw_except),
		.illegal_i         (raw_illegal),
		.starved_i         (starved_o),
		.cir_err_i         (cir_err_i),
		.rs1_o             (rs1_o),
		.rs2_o             (rs2_o),
		.rd_o              (rd_o),
		.imm_o             (imm_o),
		.alusrc_a_o        (alusrc_a_o),
		.alusrc_b_o        (alusrc_b_o),
		.aluop_o           (aluop_o),
		.memop_o           (memop_o),
		.branchcond_o      (branchcond_o),
		.addr_offs_o       (addr_offs_o),
		.addr_is_regoffs_o (addr_is_regoffs_o),
		.except_o          (except_o)
	);

endmodule

// File: rv_instr_decoder.sv
// --------------------
// RV32I instruction decoder
// turns one instruction word into raw control fields,
// immediates and an illegal flag, with no gating applied
// --------------------

`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_instr_decoder (
	input  logic [`XLEN-1:0]          instr_i,
	output logic [`REG_ADDR_W-1:0]    rs1_o,
	output logic [`REG_ADDR_W-1:0]    rs2_o,
	output logic [`REG_ADDR_W-1:0]    rd_o,
	output logic [`XLEN-1:0]          imm_o,
	output rv_decode_pkg::alusrc_a_e  alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e  alusrc_b_o,
	output rv_decode_pkg::alu_op_e    aluop_o,
	output rv_decode_pkg::mem_op_e    memop_o,
	output rv_decode_pkg::bcond_e     branchcond_o,
	output logic [`XLEN-1:0]          addr_offs_o,
	output logic                      addr_is_regoffs_o,
	output rv_decode_pkg::except_e    except_o,
	output logic                      illegal_o
);
	import rv_decode_pkg::*;

	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	opcode_e          opcode;

	// shared by OP and OP-IMM, alt selects SUB and SRA
	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
		case (f3)
		3'b000: alu_decode = alt ? ALUOP_SUB : ALUOP_ADD;
		3'b001: alu_decode = ALUOP_SLL;
		3'b010: alu_decode = ALUOP_LT;
		3'b011: alu_decode = ALUOP_LTU;
		3'b100: alu_decode = ALUOP_XOR;
		3'b101: alu_decode = alt ? ALUOP_SRA : ALUOP_SRL;
		3'b110: alu_decode = ALUOP_OR;
		default: alu_decode = ALUOP_AND;
		endcase
	endfunction

	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign opcode = opcode_e'(instr_i[`OPC_MSB:`OPC_LSB]);

	// --------------------
	// immediate formats

	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// --------------------
	// control decode

	always_comb begin
		rs1_o             = instr_i[19:15];
		rs2_o             = instr_i[24:20];
		rd_o              = instr_i[11:7];
		imm_o             = imm_i;
		alusrc_a_o        = ALUSRCA_RS1;
		alusrc_b_o        = ALUSRCB_RS2;
		aluop_o           = ALUOP_ADD;
		memop_o           = MEMOP_NONE;
		branchcond_o      = BCOND_NEVER;
		addr_offs_o       = '0;
		addr_is_regoffs_o = 1'b0;
		except_o          = EXCEPT_NONE;
		illegal_o         = 1'b0;

		case (opcode)
		OPC_LOAD: begin
			rs2_o             = '0;
			addr_offs_o       = imm_i;
			addr_is_regoffs_o = 1'b1;
			case (funct3)
			3'b000: memop_o = MEMOP_LB;
			3'b001: memop_o = MEMOP_LH;
			3'b010: memop_o = MEMOP_LW;
			3'b100: memop_o = MEMOP_LBU;
			3'b101: memop_o = MEMOP_LHU;
			default: illegal_o = 1'b1;
			endcase
		end
		OPC_STORE: begin
			// store data rides through the ALU as operand B
			rd_o              = '0;
			aluop_o           = ALUOP_RS2;
			addr_offs_o       = imm_s;
			addr_is_regoffs_o = 1'b1;
			case (funct3)
			3'b000: memop_o = MEMOP_SB;
			3'b001: memop_o = MEMOP_SH;
			3'b010: memop_o = MEMOP_SW;
			default: illegal_o = 1'b1;
			endcase
		end
		OPC_BRANCH: begin
			rd_o         = '0;
			addr_offs_o  = imm_b;
			aluop_o      = funct3[2] ? (funct3[1] ? ALUOP_LTU : ALUOP_LT) : ALUOP_SUB;
			branchcond_o = funct3[0] ? BCOND_ZERO : BCOND_NZERO;
			// BEQ and BNE compare by subtraction, so the sense is reversed
			if (!funct3[2])
				branchcond_o = funct3[0] ? BCOND_NZERO : BCOND_ZERO;
			illegal_o = funct3[2:1] == 2'b01;
		end
		OPC_JAL, OPC_JALR: begin
			// ALU produces the link address PC + 4
			rs2_o        = '0;
			imm_o        = `XLEN'd4;
			alusrc_a_o   = ALUSRCA_PC;
			alusrc_b_o   = ALUSRCB_IMM;
			branchcond_o = BCOND_ALWAYS;
			if (opcode == OPC_JAL) begin
				rs1_o       = '0;
				addr_offs_o = imm_j;
			end else begin
				addr_offs_o       = imm_i;
				addr_is_regoffs_o = 1'b1;
				illegal_o         = funct3 != 3'b000;
			end
		end
		OPC_LUI, OPC_AUIPC: begin
			rs1_o      = '0;
			rs2_o      = '0;
			imm_o      = imm_u;
			alusrc_b_o = ALUSRCB_IMM;
			aluop_o    = opcode == OPC_LUI ? ALUOP_RS2 : ALUOP_ADD;
			alusrc_a_o = opcode == OPC_LUI ? ALUSRCA_RS1 : ALUSRCA_PC;
		end
		OPC_OP_IMM: begin
			rs2_o      = '0;
			alusrc_b_o = ALUSRCB_IMM;
			aluop_o    = alu_decode(funct3, funct3 == 3'b101 && funct7[5]);
			illegal_o  = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
				(funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000);
		end
		OPC_OP: begin
			aluop_o   = alu_decode(funct3, funct7[5]);
			illegal_o = !(funct7 == 7'b0000000 ||
				(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
		end
		OPC_MISC_MEM: begin
			// FENCE has no effect on an in-order core with one bus
			rs1_o     = '0;
			rs2_o     = '0;
			rd_o      = '0;
			illegal_o = funct3 != 3'b000;
		end
		OPC_SYSTEM: begin
			rs1_o = '0;
			rs2_o = '0;
			rd_o  = '0;
			if (instr_i == 32'h0000_0073)
				except_o = EXCEPT_ECALL;
			else if (instr_i == 32'h0010_0073)
				except_o = EXCEPT_EBREAK;
			else
				illegal_o = 1'b1;
		end
		default: begin
			illegal_o = 1'b1;
		end
		endcase
	end

endmodule

// File: rv_pc_ctrl.sv
// --------------------
// decode PC control
// holds the PC of the current instruction, detects an empty
// instruction buffer and tells fetch when a word is consumed
// --------------------

`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module rv_pc_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             cir_vld_i,
	input  logic             x_stall_i,
	input  logic             jump_now_i,
	input  logic [`XLEN-1:0] jump_target_i,
	output logic             starved_o,
	output logic             cir_use_o,
	output logic [`XLEN-1:0] pc_o
);

	logic [`XLEN-1:0] pc_q;
	logic [`XLEN-1:0] pc_seq;

	// --------------------
	// buffer handshake

	// nothing to decode when fetch has no valid word
	assign starved_o = !cir_vld_i;

	// the word is consumed only when execute can take it
	assign cir_use_o = !starved_o && !x_stall_i;

	// --------------------
	// PC register

	assign pc_seq = pc_q + `XLEN'd4;

	// a redirect from execute overrides sequential advance,
	// including while decode is stalled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= `RESET_VECTOR;
		end else if (jump_now_i) begin
			pc_q <= jump_target_i;
		end else if (cir_use_o) begin
			pc_q <= pc_seq;
		end
	end

	assign pc_o = pc_q;

endmodule

// File: tb_decode_stage.sv
// --------------------
// RV32I decode stage testbench
// random instruction words against a reference decode,
// with stall, starvation and redirect traffic
// --------------------

`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module tb_decode_stage;
	import rv_decode_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int N_IDLE = 4;
	localparam int N_DECODE = 400;
	localparam int N_STALL = 200;
	localparam int N_JUMP = 150;
	localparam int CYCLE_LIMIT = RESET_CYCLES + N_IDLE + N_DECODE + N_STALL + N_JUMP + 100;

	typedef struct packed {
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
		alusrc_a_e   srca;
		alusrc_b_e   srcb;
		alu_op_e     aluop;
		mem_op_e     memop;
		bcond_e      bcond;
		logic [31:0] offs;
		logic        regoffs;
		except_e     exc;
	} decode_t;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic [`XLEN-1:0]       cir_i;
	logic                   cir_vld_i;
	logic                   cir_err_i;
	logic                   x_stall_i;
	logic                   jump_now_i;
	logic [`XLEN-1:0]       jump_target_i;
	logic                   cir_use_o;
	logic                   starved_o;
	logic [`XLEN-1:0]       pc_o;
	logic [`REG_ADDR_W-1:0] rs1_o;
	logic [`REG_ADDR_W-1:0] rs2_o;
	logic [`REG_ADDR_W-1:0] rd_o;
	logic [`XLEN-1:0]       imm_o;
	alusrc_a_e              alusrc_a_o;
	alusrc_b_e              alusrc_b_o;
	alu_op_e                aluop_o;
	mem_op_e                memop_o;
	bcond_e                 branchcond_o;
	logic [`XLEN-1:0]       addr_offs_o;
	logic                   addr_is_regoffs_o;
	except_e                except_o;

	logic [31:0] rng_state = 32'hef4a_4eaf;
	logic [31:0] exp_pc = `RESET_VECTOR;
	logic        exp_use;
	decode_t     exp;
	int          error_count = 0;
	int          checked_cycles = 0;
	int          cycle_count = 0;
	int          total_errors;

	rv_decode_stage dut0 (
		.clk               (clk),
		.rst_n             (rst_n),
		.cir_i             (cir_i),
		.cir_vld_i         (cir_vld_i),
		.cir_err_i         (cir_err_i),
		.x_stall_i         (x_stall_i),
		.jump_now_i        (jump_now_i),
		.jump_target_i     (jump_target_i),
		.cir_use_o         (cir_use_o),
		.starved_o         (starved_o),
		.pc_o              (pc_o),
		.rs1_o             (rs1_o),
		.rs2_o             (rs2_o),
		.rd_o              (rd_o),
		.imm_o             (imm_o),
		.alusrc_a_o        (alusrc_a_o),
		.alusrc_b_o        (alusrc_b_o),
		.aluop_o           (aluop_o),
		.memop_o           (memop_o),
		.branchcond_o      (branchcond_o),
		.addr_offs_o       (addr_offs_o),
		.addr_is_regoffs_o (addr_is_regoffs_o),
		.except_o          (except_o)
	);

	initial begin
		forever #HALF_PERIOD clk = ~clk;
	end

	// --------------------
	// stimulus helpers

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
		case (idx)
		4'd0: return OPC_LOAD;
		4'd1: return OPC_STORE;
		4'd2: return OPC_BRANCH;
		4'd3: return OPC_JAL;
		4'd4: return OPC_JALR;
		4'd5: return OPC_LUI;
		4'd6: return OPC_AUIPC;
		4'd7: return OPC_OP_IMM;
		4'd8: return OPC_OP;
		4'd9: return OPC_MISC_MEM;
		default: return OPC_SYSTEM;
		endcase
	endfunction

	// mostly legal opcodes, with some raw opcodes and exact ECALL / EBREAK
	function automatic logic [31:0] random_word();
		logic [31:0] r;
		logic [31:0] w;
		r = next_rand();
		w = next_rand();
		if (r[3:0] < 4'd11)
			w[6:0] = pick_opcode(r[3:0]);
		else if (r[3:0] < 4'd13)
			w[6:0] = r[10:4];
		else if (r[3:0] == 4'd13)
			w = r[4] ? 32'h0000_0073 : 32'h0010_0073;
		else
			w[6:0] = r[4] ? OPC_OP : OPC_OP_IMM;
		// steer funct7 of OP and OP-IMM toward the legal values
		if ((w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) && r[12:11] != 2'b00)
			w[31:25] = r[13] ? 7'b0100000 : 7'b0000000;
		return w;
	endfunction

	// fetch side, a new word only after the last one was used
	task automatic drive_cycle(input logic use_err, input logic use_stall,
		input logic use_idle, input logic use_jump);
		logic [31:0] r;
		logic [31:0] t;
		@(negedge clk);
		r = next_rand();
		t = next_rand();
		if (cir_use_o || !cir_vld_i) begin
			cir_i = random_word();
			cir_vld_i = !(use_idle && r[1:0] == 2'b00);
			cir_err_i = use_err && r[5:2] == 4'd0;
		end
		x_stall_i = use_stall && r[7:6] == 2'b00;
		jump_now_i = use_jump && r[9:8] == 2'b00;
		jump_target_i = {t[31:2], 2'b00};
	endtask

	// --------------------
	// reference decode

	function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		case (f3)
		3'b000: return alt ? ALUOP_SUB : ALUOP_ADD;
		3'b001: return ALUOP_SLL;
		3'b010: return ALUOP_LT;
		3'b011: return ALUOP_LTU;
		3'b100: return ALUOP_XOR;
		3'b101: return alt ? ALUOP_SRA : ALUOP_SRL;
		3'b110: return ALUOP_OR;
		default: return ALUOP_AND;
		endcase
	endfunction

	function automatic decode_t expected_decode(input logic [31:0] w, input logic vld,
		input logic err);
		decode_t     d;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] i_imm;
		logic [31:0] s_imm;
		logic [31:0] b_imm;
		logic [31:0] u_imm;
		logic [31:0] j_imm;
		logic        illegal;
		logic        fault;
		logic        suppress;
		f3 = w[14:12];
		f7 = w[31:25];
		i_imm = {{20{w[31]}}, w[31:20]};
		s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
		b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		u_imm = {w[31:12], 12'b0};
		j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		illegal = 1'b0;
		d.rs1 = w[19:15];
		d.rs2 = w[24:20];
		d.rd = w[11:7];
		d.imm = i_imm;
		d.srca = ALUSRCA_RS1;
		d.srcb = ALUSRCB_RS2;
		d.aluop = ALUOP_ADD;
		d.memop = MEMOP_NONE;
		d.bcond = BCOND_NEVER;
		d.offs = '0;
		d.regoffs = 1'b0;
		d.exc = EXCEPT_NONE;
		case (w[6:0])
		OPC_LOAD: begin
			d.rs2 = '0;
			d.offs = i_imm;
			d.regoffs = 1'b1;
			case (f3)
			3'b000: d.memop = MEMOP_LB;
			3'b001: d.memop = MEMOP_LH;
			3'b010: d.memop = MEMOP_LW;
			3'b100: d.memop = MEMOP_LBU;
			3'b101: d.memop = MEMOP_LHU;
			default: illegal = 1'b1;
			endcase
		end
		OPC_STORE: begin
			d.rd = '0;
			d.aluop = ALUOP_RS2;
			d.offs = s_imm;
			d.regoffs = 1'b1;
			case (f3)
			3'b000: d.memop = MEMOP_SB;
			3'b001: d.memop = MEMOP_SH;
			3'b010: d.memop = MEMOP_SW;
			default: illegal = 1'b1;
			endcase
		end
		OPC_BRANCH: begin
			d.rd = '0;
			d.offs = b_imm;
			case (f3)
			3'b000, 3'b001: d.aluop = ALUOP_SUB;
			3'b100, 3'b101: d.aluop = ALUOP_LT;
			3'b110, 3'b111: d.aluop = ALUOP_LTU;
			default: begin
				d.aluop = ALUOP_SUB;
				illegal = 1'b1;
			end
			endcase
			// BEQ, BGE and BGEU are taken on a zero compare result
			if (f3 == 3'b000 || f3 == 3'b101 || f3 == 3'b111)
				d.bcond = BCOND_ZERO;
			else
				d.bcond = BCOND_NZERO;
		end
		OPC_JAL, OPC_JALR: begin
			d.rs2 = '0;
			d.imm = 32'd4;
			d.srca = ALUSRCA_PC;
			d.srcb = ALUSRCB_IMM;
			d.bcond = BCOND_ALWAYS;
			if (w[6:0] == OPC_JAL) begin
				d.rs1 = '0;
				d.offs = j_imm;
			end else begin
				d.offs = i_imm;
				d.regoffs = 1'b1;
				illegal = f3 != 3'b000;
			end
		end
		OPC_LUI, OPC_AUIPC: begin
			d.rs1 = '0;
			d.rs2 = '0;
			d.imm = u_imm;
			d.srcb = ALUSRCB_IMM;
			d.aluop = (w[6:0] == OPC_LUI) ? ALUOP_RS2 : ALUOP_ADD;
			d.srca = (w[6:0] == OPC_LUI) ? ALUSRCA_RS1 : ALUSRCA_PC;
		end
		OPC_OP_IMM: begin
			d.rs2 = '0;
			d.srcb = ALUSRCB_IMM;
			d.aluop = alu_from_funct3(f3, f3 == 3'b101 && f7[5]);
			if (f3 == 3'b001 && f7 != 7'h00)
				illegal = 1'b1;
			if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)
				illegal = 1'b1;
		end
		OPC_OP: begin
			d.aluop = alu_from_funct3(f3, f7[5]);
			illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
		end
		OPC_MISC_MEM: begin
			d.rs1 = '0;
			d.rs2 = '0;
			d.rd = '0;
			illegal = f3 != 3'b000;
		end
		OPC_SYSTEM: begin
			d.rs1 = '0;
			d.rs2 = '0;
			d.rd = '0;
			if (w == 32'h0000_0073)
				d.exc = EXCEPT_ECALL;
			else if (w == 32'h0010_0073)
				d.exc = EXCEPT_EBREAK;
			else
				illegal = 1'b1;
		end
		default: illegal = 1'b1;
		endcase
		// suppression of a starved, faulted or illegal word
		fault = err && vld;
		suppress = !vld || fault || illegal;
		if (suppress) begin
			d.rs1 = '0;
			d.rs2 = '0;
			d.rd = '0;
			d.memop = MEMOP_NONE;
			d.bcond = BCOND_NEVER;
			d.regoffs = 1'b1;
		end
		if (fault)
			d.exc = EXCEPT_INSTR_FAULT;
		else if (illegal && vld)
			d.exc = EXCEPT_INSTR_ILLEGAL;
		else if (suppress)
			d.exc = EXCEPT_NONE;
		return d;
	endfunction

	// --------------------
	// checking

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("FAILED %s: got %h, expected %h at %0t", name, got, want, $time);
			error_count++;
		end
	endtask

	// sample one step before the rising edge, when all outputs have settled
	always begin
		@(negedge clk);
		#(HALF_PERIOD - 1);
		if (rst_n) begin
			exp = expected_decode(cir_i, cir_vld_i, cir_err_i);
			exp_use = cir_vld_i && !x_stall_i;
			check_value("pc_o", pc_o, exp_pc);
			check_value("starved_o", starved_o, !cir_vld_i);
			check_value("cir_use_o", cir_use_o, exp_use);
			check_value("rs1_o", rs1_o, exp.rs1);
			check_value("rs2_o", rs2_o, exp.rs2);
			check_value("rd_o", rd_o, exp.rd);
			check_value("imm_o", imm_o, exp.imm);
			check_value("alusrc_a_o", alusrc_a_o, exp.srca);
			check_value("alusrc_b_o", alusrc_b_o, exp.srcb);
			check_value("aluop_o", aluop_o, exp.aluop);
			check_value("memop_o", memop_o, exp.memop);
			check_value("branchcond_o", branchcond_o, exp.bcond);
			check_value("addr_offs_o", addr_offs_o, exp.offs);
			check_value("addr_is_regoffs_o", addr_is_regoffs_o, exp.regoffs);
			check_value("except_o", except_o, exp.exc);
			checked_cycles++;
			// PC model, a jump beats sequential advance
			if (jump_now_i)
				exp_pc = jump_target_i;
			else if (exp_use)
				exp_pc = exp_pc + 32'd4;
		end else begin
			exp_pc = `RESET_VECTOR;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	// --------------------
	// test sequence

	initial begin
		rst_n = 1'b0;
		cir_i = '0;
		cir_vld_i = 1'b0;
		cir_err_i = 1'b0;
		x_stall_i = 1'b0;
		jump_now_i = 1'b0;
		jump_target_i = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// empty buffer after reset, the word on cir_i must be ignored
		repeat (N_IDLE) begin
			@(negedge clk);
			cir_i = random_word();
		end

		// decode of every kind of word, with some fetch errors
		repeat (N_DECODE) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);

		// back-pressure and gaps in the instruction stream
		repeat (N_STALL) drive_cycle(1'b0, 1'b1, 1'b1, 1'b0);

		// redirects mixed with stalls
		repeat (N_JUMP) drive_cycle(1'b1, 1'b1, 1'b1, 1'b1);

		@(negedge clk);
		jump_now_i = 1'b0;
		x_stall_i = 1'b0;
		repeat (2) @(negedge clk);

		total_errors = error_count + dut0.decode_asserts0.fail_count;
		$display("checked %0d cycles: %0d value errors, %0d assertion errors",
			checked_cycles, error_count, dut0.decode_asserts0.fail_count);
		if (total_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
